// File: include/ray_cfg.svh
`ifndef RAY_CFG_SVH
`define RAY_CFG_SVH

// fp24 layout: 1 sign bit, 7 exponent bits, 16 mantissa bits
`define FP24_EXP_W 7
`define FP24_MANT_W 16
`define FP24_BIAS 63

// 1.0 in fp24
`define FP24_ONE 24'h3f0000

// Unit latencies in clock cycles
`define FP24_MUL_LAT 1
`define FP24_ADD_LAT 2

// Mirror reflection pipeline depth
`define SPEC_REFLECT_DELAY 8

// Hit in to bounce out
`define RAY_RFLX_DELAY 8

`endif

// File: logic/ray_pkg.sv
`include "ray_cfg.svh"

package ray_pkg;

  // Raw fp24 word
  typedef logic [`FP24_EXP_W+`FP24_MANT_W:0] fp24_t;

  typedef struct packed {
    logic                    sign;
    logic [`FP24_EXP_W-1:0]  exp;
    logic [`FP24_MANT_W-1:0] mant;
  } fp24_fields_t;

  // Same word seen as raw bits or as its fields
  typedef union packed {
    fp24_t        raw;
    fp24_fields_t f;
  } fp24_u;

  typedef struct packed {
    fp24_t x;
    fp24_t y;
    fp24_t z;
  } fp24_vec3_t;

  typedef struct packed {
    fp24_t r;
    fp24_t g;
    fp24_t b;
  } fp24_color_t;

  typedef struct packed {
    fp24_color_t color;
    fp24_color_t spec_color;
    fp24_color_t emit_color;
    logic [7:0]  specular_prob;
  } material_t;

  typedef struct packed {
    fp24_vec3_t  dir;
    fp24_color_t color;
    fp24_color_t income_light;
  } ray_in_t;

  typedef struct packed {
    fp24_vec3_t pos;
    fp24_vec3_t normal;
    material_t  mat;
  } hit_t;

  typedef struct packed {
    fp24_vec3_t  dir;
    fp24_vec3_t  origin;
    fp24_color_t color;
    fp24_color_t income_light;
  } bounce_t;

endpackage

// File: logic/delay_pipe.sv
`timescale 1ns/1ps

module delay_pipe #(
  parameter int WIDTH      = 1,
  parameter int DEPTH      = 1,
  parameter bit RESET_ZERO = 1'b0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] in,
  output logic [WIDTH-1:0] out
);

  logic [WIDTH-1:0] stage [DEPTH];

  always_ff @(posedge clk) begin
    if (RESET_ZERO && !rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out = stage[DEPTH-1];

endmodule

// File: logic/fp24_mul.sv
`timescale 1ns/1ps
`include "ray_cfg.svh"

module fp24_mul (
  input  logic           clk,
  input  ray_pkg::fp24_t a,
  input  ray_pkg::fp24_t b,
  output ray_pkg::fp24_t prod
);

  localparam int EW = `FP24_EXP_W;
  localparam int MW = `FP24_MANT_W;

  ray_pkg::fp24_u  ua;
  ray_pkg::fp24_u  ub;
  ray_pkg::fp24_u  res;
  logic [2*MW+1:0] mprod;
  int              exp_sum;

  assign ua.raw = a;
  assign ub.raw = b;

  // Mantissas with hidden ones, product lies in [1, 4)
  assign mprod = {1'b1, ua.f.mant} * {1'b1, ub.f.mant};

  always_comb begin
    exp_sum    = int'(ua.f.exp) + int'(ub.f.exp) - `FP24_BIAS + int'(mprod[2*MW+1]);
    res.f.sign = ua.f.sign ^ ub.f.sign;
    res.f.exp  = exp_sum[EW-1:0];
    // Renormalize by one place when the product reached 2
    if (mprod[2*MW+1]) begin
      res.f.mant = mprod[2*MW:MW+1];
    end else begin
      res.f.mant = mprod[2*MW-1:MW];
    end
    if (ua.f.exp == '0 || ub.f.exp == '0 || exp_sum <= 0) begin
      res.raw = '0;
    end else if (exp_sum > 2**EW - 1) begin
      // Saturate to largest finite magnitude
      res.f.exp  = '1;
      res.f.mant = '1;
    end
  end

  always_ff @(posedge clk) begin
    prod <= res.raw;
  end

endmodule

// File: logic/fp24_add.sv
`timescale 1ns/1ps
`include "ray_cfg.svh"

module fp24_add (
  input  logic           clk,
  input  ray_pkg::fp24_t a,
  input  ray_pkg::fp24_t b,
  input  logic           is_sub,
  output ray_pkg::fp24_t sum
);

  localparam int EW = `FP24_EXP_W;
  localparam int MW = `FP24_MANT_W;

  ray_pkg::fp24_u ua;
  ray_pkg::fp24_u ub;
  ray_pkg::fp24_u big;
  ray_pkg::fp24_u small_op;
  logic           b_sign;
  logic           a_big;
  logic [EW-1:0]  exp_diff;
  logic [MW:0]    small_mant_al;

  // Stage one registers
  logic           s1_sign;
  logic [EW-1:0]  s1_exp;
  logic [MW:0]    s1_big_mant;
  logic [MW:0]    s1_small_mant;
  logic           s1_sub;

  // Stage two
  logic [MW+1:0]  mag;
  logic [MW+1:0]  norm;
  logic [4:0]     lead;
  int             exp_new;
  ray_pkg::fp24_u res;

  assign ua.raw = a;
  assign ub.raw = b;

  // Order operands by magnitude and align the smaller one
  always_comb begin
    b_sign          = ub.f.sign ^ is_sub;
    a_big           = {ua.f.exp, ua.f.mant} >= {ub.f.exp, ub.f.mant};
    big             = a_big ? ua : ub;
    small_op        = a_big ? ub : ua;
    big.f.sign      = a_big ? ua.f.sign : b_sign;
    small_op.f.sign = a_big ? b_sign : ua.f.sign;
    exp_diff        = big.f.exp - small_op.f.exp;
    if (small_op.f.exp == '0 || exp_diff > MW) begin
      small_mant_al = '0;
    end else begin
      small_mant_al = {1'b1, small_op.f.mant} >> exp_diff;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign       <= big.f.sign;
    s1_exp        <= big.f.exp;
    s1_big_mant   <= (big.f.exp == '0) ? '0 : {1'b1, big.f.mant};
    s1_small_mant <= small_mant_al;
    s1_sub        <= big.f.sign ^ small_op.f.sign;
  end

  always_comb begin
    if (s1_sub) begin
      mag = {1'b0, s1_big_mant} - {1'b0, s1_small_mant};
    end else begin
      mag = {1'b0, s1_big_mant} + {1'b0, s1_small_mant};
    end
    // Highest set bit wins the leading one search
    lead = '0;
    for (int i = 0; i < MW + 2; i++) begin
      if (mag[i]) begin
        lead = 5'(i);
      end
    end
    norm       = mag << (MW + 1 - int'(lead));
    exp_new    = int'(s1_exp) + int'(lead) - MW;
    res.f.sign = s1_sign;
    res.f.exp  = exp_new[EW-1:0];
    res.f.mant = norm[MW:1];
    // Exact cancellation gives +0
    if (mag == '0 || exp_new <= 0) begin
      res.raw = '0;
    end else if (exp_new > 2**EW - 1) begin
      res.f.exp  = '1;
      res.f.mant = '1;
    end
  end

  always_ff @(posedge clk) begin
    sum <= res.raw;
  end

endmodule

// File: logic/prng8.sv
`timescale 1ns/1ps

module prng8 (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] seed,
  output logic [7:0] rng
);

  // Taps for x^8 + x^6 + x^5 + x^4 + 1, right-shifting form
  localparam logic [7:0] TAPS = 8'hb8;

  logic [7:0] state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // All-zero state would lock up
      state <= (seed == 8'h00) ? 8'h01 : seed;
    end else if (state[0]) begin
      state <= (state >> 1) ^ TAPS;
    end else begin
      state <= state >> 1;
    end
  end

  assign rng = state;

endmodule

// File: logic/specular_reflect.sv
`timescale 1ns/1ps
`include "ray_cfg.svh"

// out = in - 2 * dot(in, n) * n, normal assumed unit length
module specular_reflect (
  input  logic                clk,
  input  logic                rst_n,
  input  ray_pkg::fp24_vec3_t in_dir,
  input  ray_pkg::fp24_vec3_t normal,
  output ray_pkg::fp24_vec3_t out_dir
);

  localparam int NRM_DLY = `FP24_MUL_LAT + 2 * `FP24_ADD_LAT;
  localparam int DIR_DLY = NRM_DLY + `FP24_MUL_LAT;

  ray_pkg::fp24_t [2:0] dir_a;
  ray_pkg::fp24_t [2:0] nrm_a;
  ray_pkg::fp24_t [2:0] prod_a;
  ray_pkg::fp24_t [2:0] nrm_d_a;
  ray_pkg::fp24_t [2:0] dir_d_a;
  ray_pkg::fp24_t [2:0] scaled_a;
  ray_pkg::fp24_t [2:0] out_a;
  ray_pkg::fp24_vec3_t  nrm_d;
  ray_pkg::fp24_vec3_t  dir_d;
  ray_pkg::fp24_t       xy_sum;
  ray_pkg::fp24_t       z_prod_d;
  ray_pkg::fp24_t       dot;
  ray_pkg::fp24_u       dot_u;
  ray_pkg::fp24_u       dot_x2;

  assign dir_a = in_dir;
  assign nrm_a = normal;

  // Component products, lanes 2..0 are x, y, z
  for (genvar i = 0; i < 3; i++) begin : g_dot_mul
    fp24_mul u_mul (.clk(clk), .a(dir_a[i]), .b(nrm_a[i]), .prod(prod_a[i]));
  end

  // Dot product add tree, z waits for the x+y sum
  fp24_add u_add_xy (.clk(clk), .a(prod_a[2]), .b(prod_a[1]), .is_sub(1'b0), .sum(xy_sum));

  delay_pipe #(.WIDTH(24), .DEPTH(`FP24_ADD_LAT)) u_z_pipe (
    .clk(clk), .rst_n(rst_n), .in(prod_a[0]), .out(z_prod_d)
  );

  fp24_add u_add_dot (.clk(clk), .a(xy_sum), .b(z_prod_d), .is_sub(1'b0), .sum(dot));

  // Times two by exponent bump, zero and top exponent pass unchanged
  assign dot_u.raw = dot;

  always_comb begin
    dot_x2 = dot_u;
    if (dot_u.f.exp != '0 && dot_u.f.exp != '1) begin
      dot_x2.f.exp = dot_u.f.exp + 1'b1;
    end
  end

  delay_pipe #(.WIDTH(72), .DEPTH(NRM_DLY)) u_nrm_pipe (
    .clk(clk), .rst_n(rst_n), .in(normal), .out(nrm_d)
  );

  delay_pipe #(.WIDTH(72), .DEPTH(DIR_DLY)) u_dir_pipe (
    .clk(clk), .rst_n(rst_n), .in(in_dir), .out(dir_d)
  );

  assign nrm_d_a = nrm_d;
  assign dir_d_a = dir_d;

  for (genvar i = 0; i < 3; i++) begin : g_reflect
    fp24_mul u_scale (.clk(clk), .a(dot_x2.raw), .b(nrm_d_a[i]), .prod(scaled_a[i]));
    fp24_add u_sub (
      .clk(clk), .a(dir_d_a[i]), .b(scaled_a[i]), .is_sub(1'b1), .sum(out_a[i])
    );
  end

  assign out_dir = out_a;

endmodule

// File: logic/ray_reflector.sv
`timescale 1ns/1ps
`include "ray_cfg.svh"

// Bounce stage: new direction, origin, color and gathered light for one hit
module ray_reflector (
  input  logic                clk,
  input  logic                rst_n,
  input  ray_pkg::ray_in_t    ray,
  input  ray_pkg::hit_t       hit,
  input  logic                hit_valid,
  input  logic [7:0]          lfsr_seed,
  output ray_pkg::bounce_t    bounce,
  output logic                reflect_done
);

  localparam int COLOR_DLY = `RAY_RFLX_DELAY - `FP24_MUL_LAT;
  localparam int LIGHT_DLY = `RAY_RFLX_DELAY - `FP24_MUL_LAT - `FP24_ADD_LAT;

  logic [7:0]           rng;
  logic                 spec_now;
  logic                 is_specular;
  logic                 is_specular_d;
  ray_pkg::fp24_color_t sel_color;
  ray_pkg::fp24_t [2:0] ray_col_a;
  ray_pkg::fp24_t [2:0] sel_col_a;
  ray_pkg::fp24_t [2:0] col_prod_a;
  ray_pkg::fp24_t [2:0] emit_a;
  ray_pkg::fp24_t [2:0] emit_prod_a;
  ray_pkg::fp24_t [2:0] light_in_d_a;
  ray_pkg::fp24_t [2:0] light_sum_a;
  ray_pkg::fp24_color_t col_prod;
  ray_pkg::fp24_color_t light_in_d;
  ray_pkg::fp24_color_t light_sum;
  ray_pkg::fp24_vec3_t  refl_dir;
  ray_pkg::fp24_vec3_t  normal_d;

  delay_pipe #(.WIDTH(1), .DEPTH(`RAY_RFLX_DELAY), .RESET_ZERO(1'b1)) u_done_pipe (
    .clk(clk), .rst_n(rst_n), .in(hit_valid), .out(reflect_done)
  );

  // Bounce choice, rng runs 1..255
  prng8 u_prng (.clk(clk), .rst_n(rst_n), .seed(lfsr_seed), .rng(rng));

  assign spec_now = rng <= hit.mat.specular_prob;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_specular <= 1'b0;
    end else begin
      is_specular <= spec_now;
    end
  end

  delay_pipe #(.WIDTH(1), .DEPTH(`RAY_RFLX_DELAY - 1), .RESET_ZERO(1'b1)) u_spec_pipe (
    .clk(clk), .rst_n(rst_n), .in(is_specular), .out(is_specular_d)
  );

  // Direction branch
  specular_reflect u_spec_reflect (
    .clk(clk), .rst_n(rst_n), .in_dir(ray.dir), .normal(hit.normal), .out_dir(refl_dir)
  );

  delay_pipe #(.WIDTH(72), .DEPTH(`SPEC_REFLECT_DELAY)) u_normal_pipe (
    .clk(clk), .rst_n(rst_n), .in(hit.normal), .out(normal_d)
  );

  // Diffuse bounce leaves along the normal
  assign bounce.dir = is_specular_d ? refl_dir : normal_d;

  delay_pipe #(.WIDTH(72), .DEPTH(`RAY_RFLX_DELAY)) u_origin_pipe (
    .clk(clk), .rst_n(rst_n), .in(hit.pos), .out(bounce.origin)
  );

  // Color branch, picked in the hit cycle straight from the compare
  assign sel_color = spec_now ? hit.mat.spec_color : hit.mat.color;
  assign ray_col_a = ray.color;
  assign sel_col_a = sel_color;
  assign emit_a    = hit.mat.emit_color;

  for (genvar i = 0; i < 3; i++) begin : g_color
    fp24_mul u_tint (.clk(clk), .a(ray_col_a[i]), .b(sel_col_a[i]), .prod(col_prod_a[i]));
  end

  assign col_prod = col_prod_a;

  delay_pipe #(.WIDTH(72), .DEPTH(COLOR_DLY)) u_color_pipe (
    .clk(clk), .rst_n(rst_n), .in(col_prod), .out(bounce.color)
  );

  // Gathered light, old light waits out the emission multiply
  delay_pipe #(.WIDTH(72), .DEPTH(`FP24_MUL_LAT)) u_light_in_pipe (
    .clk(clk), .rst_n(rst_n), .in(ray.income_light), .out(light_in_d)
  );

  assign light_in_d_a = light_in_d;

  for (genvar i = 0; i < 3; i++) begin : g_light
    fp24_mul u_emit (.clk(clk), .a(ray_col_a[i]), .b(emit_a[i]), .prod(emit_prod_a[i]));
    fp24_add u_accum (
      .clk(clk), .a(emit_prod_a[i]), .b(light_in_d_a[i]), .is_sub(1'b0),
      .sum(light_sum_a[i])
    );
  end

  assign light_sum = light_sum_a;

  delay_pipe #(.WIDTH(72), .DEPTH(LIGHT_DLY)) u_light_pipe (
    .clk(clk), .rst_n(rst_n), .in(light_sum), .out(bounce.income_light)
  );

endmodule

// File: tb/ray_reflector_properties.sv
`timescale 1ns/1ps
`include "ray_cfg.svh"

module ray_reflector_properties (
  input logic       clk,
  input logic       rst_n,
  input logic       hit_valid,
  input logic       reflect_done,
  input logic [7:0] rng
);

  // Counts cycles since reset and saturates once the done pipe is full
  logic [3:0] run_cnt;
  int         fail_count = 0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_cnt <= '0;
    end else if (run_cnt != 4'(`RAY_RFLX_DELAY)) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  a_done_low_in_reset : assert property (@(posedge clk) !rst_n |=> !reflect_done)
    else begin
      $error("reflect_done high during or just after reset");
      fail_count++;
    end

  a_done_delay : assert property (@(posedge clk) disable iff (!rst_n)
    (run_cnt == 4'(`RAY_RFLX_DELAY)) |-> (reflect_done == $past(hit_valid, `RAY_RFLX_DELAY)))
    else begin
      $error("reflect_done does not follow hit_valid by the pipeline delay");
      fail_count++;
    end

  a_rng_nonzero : assert property (@(posedge clk) disable iff (!rst_n) rng != 8'h00)
    else begin
      $error("LFSR reached the all-zero state");
      fail_count++;
    end

endmodule

bind ray_reflector ray_reflector_properties u_props (
  .clk(clk), .rst_n(rst_n), .hit_valid(hit_valid), .reflect_done(reflect_done), .rng(rng)
);

// File: tb/ray_reflector_tb.sv
`timescale 1ns/1ps
`include "ray_cfg.svh"

module ray_reflector_tb;

  localparam int N_TESTS     = 6;
  localparam int N_RAND      = 24;
  localparam int WATCHDOG_NS = (N_TESTS + N_RAND + `RAY_RFLX_DELAY + 20) * 20;

  // Exactly representable fp24 constants
  localparam ray_pkg::fp24_t ZERO     = 24'h000000;
  localparam ray_pkg::fp24_t EIGHTH   = 24'h3c0000;
  localparam ray_pkg::fp24_t QTR      = 24'h3d0000;
  localparam ray_pkg::fp24_t HALF     = 24'h3e0000;
  localparam ray_pkg::fp24_t THREE_Q  = 24'h3e8000;
  localparam ray_pkg::fp24_t ONE      = `FP24_ONE;
  localparam ray_pkg::fp24_t ONE_HALF = 24'h3f8000;
  localparam ray_pkg::fp24_t TWO      = 24'h400000;
  localparam ray_pkg::fp24_t NHALF    = 24'hbe0000;
  localparam ray_pkg::fp24_t NONE     = 24'hbf0000;
  localparam ray_pkg::fp24_t NTWO     = 24'hc00000;

  logic                 clk;
  logic                 rst_n;
  ray_pkg::ray_in_t     ray;
  ray_pkg::hit_t        hit;
  logic                 hit_valid;
  logic [7:0]           lfsr_seed;
  ray_pkg::bounce_t     bounce;
  logic                 reflect_done;

  // Stimulus table with the result under each bounce type
  string                names [N_TESTS];
  ray_pkg::ray_in_t     rays [N_TESTS];
  ray_pkg::hit_t        hits [N_TESTS];
  ray_pkg::fp24_vec3_t  mirror_dirs [N_TESTS];
  ray_pkg::fp24_color_t diffuse_cols [N_TESTS];
  ray_pkg::fp24_color_t specular_cols [N_TESTS];
  ray_pkg::fp24_color_t lights [N_TESTS];
  int                   n_loaded = 0;

  ray_pkg::bounce_t     exp_q [$];
  string                name_q [$];
  int                   due_q [$];
  int                   neg_count = 0;
  int                   error_count = 0;
  int                   seed = 94;

  ray_reflector dut (
    .clk(clk), .rst_n(rst_n), .ray(ray), .hit(hit), .hit_valid(hit_valid),
    .lfsr_seed(lfsr_seed), .bounce(bounce), .reflect_done(reflect_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic ray_pkg::fp24_vec3_t vec(ray_pkg::fp24_t x, ray_pkg::fp24_t y,
                                              ray_pkg::fp24_t z);
    return {x, y, z};
  endfunction

  function automatic ray_pkg::fp24_color_t rgb(ray_pkg::fp24_t r, ray_pkg::fp24_t g,
                                               ray_pkg::fp24_t b);
    return {r, g, b};
  endfunction

  function automatic ray_pkg::ray_in_t make_ray(ray_pkg::fp24_vec3_t dir,
                                                ray_pkg::fp24_color_t color,
                                                ray_pkg::fp24_color_t light);
    ray_pkg::ray_in_t r;
    r.dir          = dir;
    r.color        = color;
    r.income_light = light;
    return r;
  endfunction

  function automatic ray_pkg::hit_t make_hit(ray_pkg::fp24_vec3_t pos, ray_pkg::fp24_vec3_t n,
                                             ray_pkg::fp24_color_t base,
                                             ray_pkg::fp24_color_t spec,
                                             ray_pkg::fp24_color_t emit, logic [7:0] prob);
    ray_pkg::hit_t h;
    h.pos               = pos;
    h.normal            = n;
    h.mat.color         = base;
    h.mat.spec_color    = spec;
    h.mat.emit_color    = emit;
    h.mat.specular_prob = prob;
    return h;
  endfunction

  task automatic add_entry(string name, ray_pkg::ray_in_t r, ray_pkg::hit_t h,
                           ray_pkg::fp24_vec3_t mirror, ray_pkg::fp24_color_t diff,
                           ray_pkg::fp24_color_t spec, ray_pkg::fp24_color_t light);
    names[n_loaded]         = name;
    rays[n_loaded]          = r;
    hits[n_loaded]          = h;
    mirror_dirs[n_loaded]   = mirror;
    diffuse_cols[n_loaded]  = diff;
    specular_cols[n_loaded] = spec;
    lights[n_loaded]        = light;
    n_loaded++;
  endtask

  task automatic load_table();
    add_entry("diffuse_up",
      make_ray(vec(HALF, NONE, ZERO), rgb(ONE, HALF, HALF), rgb(QTR, ZERO, ONE)),
      make_hit(vec(ONE, TWO, NHALF), vec(ZERO, ONE, ZERO), rgb(HALF, ONE, TWO),
               rgb(ONE, ONE, ONE), rgb(ZERO, ZERO, ZERO), 8'h00),
      vec(HALF, ONE, ZERO), rgb(HALF, HALF, ONE), rgb(ONE, HALF, HALF), rgb(QTR, ZERO, ONE));
    add_entry("specular_mirror",
      make_ray(vec(HALF, NONE, ZERO), rgb(ONE, HALF, HALF), rgb(HALF, ZERO, ONE)),
      make_hit(vec(TWO, NONE, HALF), vec(ZERO, ONE, ZERO), rgb(ONE, ONE, ONE),
               rgb(HALF, HALF, ONE_HALF), rgb(HALF, ONE, ZERO), 8'hff),
      vec(HALF, ONE, ZERO), rgb(ONE, HALF, HALF), rgb(HALF, QTR, THREE_Q), rgb(ONE, HALF, ONE));
    // Head-on ray comes straight back
    add_entry("specular_head_on",
      make_ray(vec(ZERO, ZERO, NONE), rgb(HALF, ONE, TWO), rgb(ZERO, ZERO, ZERO)),
      make_hit(vec(ZERO, ZERO, ZERO), vec(ZERO, ZERO, ONE), rgb(QTR, HALF, HALF),
               rgb(ONE, ONE, ONE), rgb(ZERO, ZERO, ZERO), 8'hff),
      vec(ZERO, ZERO, ONE), rgb(EIGHTH, HALF, ONE), rgb(HALF, ONE, TWO), rgb(ZERO, ZERO, ZERO));
    add_entry("specular_x_axis",
      make_ray(vec(NONE, HALF, ZERO), rgb(HALF, HALF, HALF), rgb(HALF, ONE, QTR)),
      make_hit(vec(NHALF, ONE, TWO), vec(ONE, ZERO, ZERO), rgb(HALF, HALF, HALF),
               rgb(TWO, HALF, ONE), rgb(ONE, ONE, ONE), 8'hff),
      vec(ONE, HALF, ZERO), rgb(QTR, QTR, QTR), rgb(ONE, QTR, HALF),
      rgb(ONE, ONE_HALF, THREE_Q));
    add_entry("diffuse_slant",
      make_ray(vec(HALF, HALF, NONE), rgb(ONE, ONE, ONE), rgb(ONE, ONE, ONE)),
      make_hit(vec(NTWO, HALF, ONE), vec(ONE, ZERO, ZERO), rgb(QTR, HALF, TWO),
               rgb(HALF, HALF, HALF), rgb(ZERO, ZERO, ZERO), 8'h00),
      vec(NHALF, HALF, NONE), rgb(QTR, HALF, TWO), rgb(HALF, HALF, HALF), rgb(ONE, ONE, ONE));
    // Emission added to a light with a negative blue term
    add_entry("emit_gather",
      make_ray(vec(ZERO, NONE, ZERO), rgb(TWO, ONE, HALF), rgb(ONE, HALF, NONE)),
      make_hit(vec(HALF, HALF, HALF), vec(ZERO, ONE, ZERO), rgb(HALF, HALF, HALF),
               rgb(ONE, ONE, ONE), rgb(HALF, QTR, ONE), 8'h00),
      vec(ZERO, ONE, ZERO), rgb(ONE, HALF, QTR), rgb(TWO, ONE, HALF), rgb(TWO, THREE_Q, NHALF));
  endtask

  // Diffuse leaves along the normal while specular takes the mirror direction
  function automatic ray_pkg::bounce_t expected_bounce(int idx, logic specular);
    ray_pkg::bounce_t b;
    b.dir          = specular ? mirror_dirs[idx] : hits[idx].normal;
    b.origin       = hits[idx].pos;
    b.color        = specular ? specular_cols[idx] : diffuse_cols[idx];
    b.income_light = lights[idx];
    return b;
  endfunction

  task automatic stop_on_error();
    error_count++;
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_vec3(string test, string field, ray_pkg::fp24_vec3_t exp,
                            ray_pkg::fp24_vec3_t act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_color(string test, string field, ray_pkg::fp24_color_t exp,
                             ray_pkg::fp24_color_t act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(string test, string field, logic exp, logic act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %b, actual %b", test, field, exp, act);
      stop_on_error();
    end
  endtask

  task automatic drive_hit(int idx, logic specular, string tag);
    ray_pkg::hit_t h;
    h                   = hits[idx];
    h.mat.specular_prob = specular ? 8'hff : 8'h00;
    ray       <= rays[idx];
    hit       <= h;
    hit_valid <= 1'b1;
    exp_q.push_back(expected_bounce(idx, specular));
    name_q.push_back(tag);
  endtask

  // Sample on the falling edge away from the driving edge
  always @(negedge clk) begin : scoreboard
    logic             exp_done;
    string            cur;
    ray_pkg::bounce_t exp_b;
    neg_count = neg_count + 1;
    exp_done  = (due_q.size() > 0) && (due_q[0] == neg_count);
    cur       = (name_q.size() > 0) ? name_q[0] : "idle";
    check_bit(cur, "reflect_done", exp_done, reflect_done);
    if (reflect_done) begin
      exp_b = exp_q.pop_front();
      void'(name_q.pop_front());
      void'(due_q.pop_front());
      check_vec3(cur, "dir", exp_b.dir, bounce.dir);
      check_vec3(cur, "origin", exp_b.origin, bounce.origin);
      check_color(cur, "color", exp_b.color, bounce.color);
      check_color(cur, "income_light", exp_b.income_light, bounce.income_light);
    end
    if (rst_n && hit_valid) begin
      due_q.push_back(neg_count + `RAY_RFLX_DELAY);
    end
  end

  // Bound assertions keep a count of their failures
  always @(negedge clk) begin
    if (dut.u_props.fail_count != 0) begin
      $display("A concurrent assertion on the DUT failed");
      stop_on_error();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: results stopped arriving from the DUT");
    stop_on_error();
  end

  initial begin : main
    int r;
    int idx;
    rst_n     = 1'b0;
    hit_valid = 1'b0;
    ray       = '0;
    hit       = '0;
    lfsr_seed = 8'd94;
    load_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // A couple of idle cycles with reflect_done expected low
    repeat (2) @(posedge clk);
    for (int i = 0; i < N_TESTS; i++) begin
      @(posedge clk);
      drive_hit(i, hits[i].mat.specular_prob == 8'hff, names[i]);
    end
    // Back-to-back stream of random entries with extreme probabilities
    for (int k = 0; k < N_RAND; k++) begin
      @(posedge clk);
      idx = $unsigned($random(seed)) % N_TESTS;
      r   = $random(seed);
      drive_hit(idx, r[0], $sformatf("rand%0d_%s", k, names[idx]));
    end
    @(posedge clk);
    hit_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (error_count == 0 && dut.u_props.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+include
logic/ray_pkg.sv
logic/delay_pipe.sv
logic/fp24_mul.sv
logic/fp24_add.sv
logic/prng8.sv
logic/specular_reflect.sv
logic/ray_reflector.sv
tb/ray_reflector_properties.sv
tb/ray_reflector_tb.sv
